/* files.f */
+incdir+hw
hw/imuldiv_pkg.sv
hw/imuldiv_mul_iter.sv
hw/imuldiv_div_iter.sv
hw/imuldiv_issue_order.sv
hw/imuldiv_top.sv
test/imuldiv_tb.sv

/* hw/imuldiv_div_iter.sv */
// ------------------------------
// iterative restoring divider
// signed and unsigned, result is {remainder, quotient}
// ------------------------------

`include "imuldiv_macros.svh"

module imuldiv_div_iter (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_valid,
  input  logic                      resp_ready
);

  import imuldiv_pkg::*;

  localparam int XLEN   = `IMULDIV_XLEN;
  localparam int STEP_W = $clog2(XLEN);

  // control
  unit_state_e       state;
  logic [STEP_W-1:0] step;
  logic              req_fire;
  logic              resp_fire;
  logic              last_step;

  // datapath
  // rq holds the partial remainder above and the quotient below
  logic [2*XLEN:0]   rq;
  logic [2*XLEN:0]   div_al;
  logic              quo_neg;
  logic              rem_neg;
  logic              is_signed;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [2*XLEN:0]   shifted;
  logic [2*XLEN:0]   diff;
  logic [XLEN-1:0]   quo_mag;
  logic [XLEN-1:0]   rem_mag;

  assign req_ready  = (state == ST_IDLE);
  assign resp_valid = (state == ST_DONE);
  assign req_fire   = req_valid && req_ready;
  assign resp_fire  = resp_valid && resp_ready;
  assign last_step  = (step == STEP_W'(XLEN - 1));

  // DIVU passes the operands through untouched
  assign is_signed = (req.op == OP_DIV);
  assign a_mag     = (is_signed && req.a[XLEN-1]) ? -req.a : req.a;
  assign b_mag     = (is_signed && req.b[XLEN-1]) ? -req.b : req.b;

  // trial subtraction, sign bit of diff tells whether the divisor fits
  assign shifted = {rq[2*XLEN-1:0], 1'b0};
  assign diff    = shifted - div_al;

  // ------------------------------
  // control FSM
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      step  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_fire) begin
            state <= ST_CALC;
            step  <= '0;
          end
        end
        ST_CALC: begin
          // one quotient bit per edge
          if (last_step) begin
            state <= ST_DONE;
          end
          step <= step + 1'b1;
        end
        ST_DONE: begin
          if (resp_fire) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------
  // restoring datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rq      <= {{(XLEN + 1){1'b0}}, a_mag};
      div_al  <= {1'b0, b_mag, {XLEN{1'b0}}};
      quo_neg <= is_signed && (req.a[XLEN-1] ^ req.b[XLEN-1]);
      // remainder follows the dividend
      rem_neg <= is_signed && req.a[XLEN-1];
    end else if (state == ST_CALC) begin
      if (!diff[2*XLEN]) begin
        // divisor fit, keep the difference and set the quotient bit
        rq <= {diff[2*XLEN:1], 1'b1};
      end else begin
        // restore, quotient bit stays 0
        rq <= shifted;
      end
    end
  end

  assign quo_mag = rq[XLEN-1:0];
  assign rem_mag = rq[2*XLEN-1:XLEN];

  // quotient and remainder get their signs back independently
  always_comb begin
    resp.result = {rem_neg ? -rem_mag : rem_mag, quo_neg ? -quo_mag : quo_mag};
  end

endmodule

/* hw/imuldiv_issue_order.sv */
// ------------------------------
// request steering and response ordering
// routes by opcode, returns results in issue order
// ------------------------------

`include "imuldiv_macros.svh"

module imuldiv_issue_order (
  input  logic                      clk,
  input  logic                      reset,
  // outside channels
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_valid,
  input  logic                      resp_ready,
  // unit request channels
  output imuldiv_pkg::muldiv_req_t  mul_req,
  output logic                      mul_req_valid,
  input  logic                      mul_req_ready,
  output imuldiv_pkg::muldiv_req_t  div_req,
  output logic                      div_req_valid,
  input  logic                      div_req_ready,
  // unit response channels
  input  imuldiv_pkg::muldiv_resp_t mul_resp,
  input  logic                      mul_resp_valid,
  output logic                      mul_resp_ready,
  input  imuldiv_pkg::muldiv_resp_t div_resp,
  input  logic                      div_resp_valid,
  output logic                      div_resp_ready
);

  import imuldiv_pkg::*;

  localparam int DEPTH = `IMULDIV_ORDER_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // unit tags stored in the queue
  localparam logic TAG_MUL = 1'b0;
  localparam logic TAG_DIV = 1'b1;

  logic             tag_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;
  logic             req_tag;
  logic             head_tag;
  logic             push;
  logic             pop;

  // circular pointer step, works for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ------------------------------
  // request side
  // ------------------------------

  always_comb begin
    case (req.op)
      OP_DIV, OP_DIVU: req_tag = TAG_DIV;
      default:         req_tag = TAG_MUL;
    endcase
  end

  // both units see the payload, only the chosen one sees valid
  assign mul_req       = req;
  assign div_req       = req;
  assign mul_req_valid = req_valid && !full && (req_tag == TAG_MUL);
  assign div_req_valid = req_valid && !full && (req_tag == TAG_DIV);
  assign req_ready     = !full && ((req_tag == TAG_DIV) ? div_req_ready : mul_req_ready);

  // ------------------------------
  // response side
  // ------------------------------

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign head_tag = tag_q[rd_ptr];

  // head of the queue owns the outside response channel
  assign resp           = (head_tag == TAG_DIV) ? div_resp : mul_resp;
  assign resp_valid     = !empty && ((head_tag == TAG_DIV) ? div_resp_valid : mul_resp_valid);
  assign mul_resp_ready = resp_ready && !empty && (head_tag == TAG_MUL);
  assign div_resp_ready = resp_ready && !empty && (head_tag == TAG_DIV);

  assign push = req_valid && req_ready;
  assign pop  = resp_valid && resp_ready;

  // ------------------------------
  // order queue
  // ------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      tag_q[wr_ptr] <= req_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hw/imuldiv_macros.svh */
// ------------------------------
// imuldiv shared parameters
// operand width and order queue size
// ------------------------------

`ifndef IMULDIV_MACROS_SVH
`define IMULDIV_MACROS_SVH

// operand width in bits
// results are twice this wide, and both units take this many steps
`define IMULDIV_XLEN 32

// issue order queue entries
// one per unit, so a full queue means both units are busy
`define IMULDIV_ORDER_DEPTH 2

`endif

/* hw/imuldiv_mul_iter.sv */
// ------------------------------
// iterative signed multiplier
// shift-and-add over magnitudes, one bit per cycle
// ------------------------------

`include "imuldiv_macros.svh"

module imuldiv_mul_iter (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_valid,
  input  logic                      resp_ready
);

  import imuldiv_pkg::*;

  localparam int XLEN   = `IMULDIV_XLEN;
  localparam int STEP_W = $clog2(XLEN);

  // control
  unit_state_e       state;
  logic [STEP_W-1:0] step;
  logic              req_fire;
  logic              resp_fire;
  logic              last_step;

  // datapath
  logic [2*XLEN-1:0] acc;
  logic [2*XLEN-1:0] mcand;
  logic [XLEN-1:0]   mplier;
  logic              neg;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;

  assign req_ready  = (state == ST_IDLE);
  assign resp_valid = (state == ST_DONE);
  assign req_fire   = req_valid && req_ready;
  assign resp_fire  = resp_valid && resp_ready;
  assign last_step  = (step == STEP_W'(XLEN - 1));

  // operand magnitudes, most negative value maps to 2^31 unsigned
  assign a_mag = req.a[XLEN-1] ? -req.a : req.a;
  assign b_mag = req.b[XLEN-1] ? -req.b : req.b;

  // ------------------------------
  // control FSM
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      step  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_fire) begin
            state <= ST_CALC;
            step  <= '0;
          end
        end
        ST_CALC: begin
          // one multiplier bit per edge, 32 edges in total
          if (last_step) begin
            state <= ST_DONE;
          end
          step <= step + 1'b1;
        end
        ST_DONE: begin
          // hold the product until the consumer takes it
          if (resp_fire) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------
  // shift-and-add datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (req_fire) begin
      acc    <= '0;
      mcand  <= {{XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      // product is negative when exactly one operand is
      neg    <= req.a[XLEN-1] ^ req.b[XLEN-1];
    end else if (state == ST_CALC) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // restore the sign on the way out
  always_comb begin
    resp.result = neg ? -acc : acc;
  end

endmodule

/* hw/imuldiv_pkg.sv */
// ------------------------------
// imuldiv types
// opcodes, unit states and channel payloads
// ------------------------------

`include "imuldiv_macros.svh"

package imuldiv_pkg;

  // ------------------------------
  // enums
  // ------------------------------

  // operation select carried with each request
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } muldiv_op_e;

  // control state shared by the multiplier and the divider
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } unit_state_e;

  // ------------------------------
  // channel payloads
  // ------------------------------

  typedef struct packed {
    muldiv_op_e                op;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } muldiv_req_t;

  // division packs {remainder, quotient}, MUL gives the full product
  typedef struct packed {
    logic [2*`IMULDIV_XLEN-1:0] result;
  } muldiv_resp_t;

endpackage

/* hw/imuldiv_top.sv */
// ------------------------------
// imuldiv top level
// issue/order block with multiplier and divider
// ------------------------------

`include "imuldiv_macros.svh"

module imuldiv_top (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_valid,
  input  logic                      resp_ready
);

  import imuldiv_pkg::*;

  // multiplier channels
  muldiv_req_t  mul_req;
  logic         mul_req_valid;
  logic         mul_req_ready;
  muldiv_resp_t mul_resp;
  logic         mul_resp_valid;
  logic         mul_resp_ready;

  // divider channels
  muldiv_req_t  div_req;
  logic         div_req_valid;
  logic         div_req_ready;
  muldiv_resp_t div_resp;
  logic         div_resp_valid;
  logic         div_resp_ready;

  imuldiv_issue_order u_issue_order (
    .clk            (clk),
    .reset          (reset),
    .req            (req),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .resp           (resp),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .mul_req        (mul_req),
    .mul_req_valid  (mul_req_valid),
    .mul_req_ready  (mul_req_ready),
    .div_req        (div_req),
    .div_req_valid  (div_req_valid),
    .div_req_ready  (div_req_ready),
    .mul_resp       (mul_resp),
    .mul_resp_valid (mul_resp_valid),
    .mul_resp_ready (mul_resp_ready),
    .div_resp       (div_resp),
    .div_resp_valid (div_resp_valid),
    .div_resp_ready (div_resp_ready)
  );

  imuldiv_mul_iter u_mul (
    .clk        (clk),
    .reset      (reset),
    .req        (mul_req),
    .req_valid  (mul_req_valid),
    .req_ready  (mul_req_ready),
    .resp       (mul_resp),
    .resp_valid (mul_resp_valid),
    .resp_ready (mul_resp_ready)
  );

  imuldiv_div_iter u_div (
    .clk        (clk),
    .reset      (reset),
    .req        (div_req),
    .req_valid  (div_req_valid),
    .req_ready  (div_req_ready),
    .resp       (div_resp),
    .resp_valid (div_resp_valid),
    .resp_ready (div_resp_ready)
  );

endmodule

/* run.sh */
#!/bin/sh
# build and run the imuldiv testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module imuldiv_tb -f files.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vimuldiv_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^=== PASS ===$"; then
  exit 0
fi
echo "pass message not found"
exit 1

/* test/imuldiv_tb.sv */
// ------------------------------
// imuldiv testbench
// directed and random ops checked against a reference queue
// ------------------------------

`include "imuldiv_macros.svh"

module imuldiv_tb;

  import imuldiv_pkg::*;

  localparam int XLEN       = `IMULDIV_XLEN;
  localparam int NUM_RANDOM = 276;
  // 300 ops of 34 cycles with 3x slack for back-pressure and stalls
  localparam int TIMEOUT_CYCLES = 300 * 34 * 3;

  logic         clk = 1'b0;
  logic         reset;
  muldiv_req_t  req;
  logic         req_valid;
  logic         req_ready;
  muldiv_resp_t resp;
  logic         resp_valid;
  logic         resp_ready;

  // reference model state
  logic [2*XLEN-1:0] exp_q [$];
  logic [2*XLEN-1:0] exp_head = '0;
  int                exp_count = 0;
  int                n_req = 0;
  int                n_resp = 0;
  int                cycle = 0;
  logic              acc_last = 1'b0;
  logic              resp_last = 1'b0;
  logic              random_ready = 1'b0;

  imuldiv_top dut (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  always #2 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // expected result straight from the arithmetic rules
  function automatic logic [2*XLEN-1:0] expected_result(input muldiv_req_t r);
    logic signed [2*XLEN-1:0] sa;
    logic signed [2*XLEN-1:0] sb;
    logic [2*XLEN-1:0]        ua;
    logic [2*XLEN-1:0]        ub;
    logic [2*XLEN-1:0]        quo;
    logic [2*XLEN-1:0]        rem;
    sa = {{XLEN{r.a[XLEN-1]}}, r.a};
    sb = {{XLEN{r.b[XLEN-1]}}, r.b};
    ua = {{XLEN{1'b0}}, r.a};
    ub = {{XLEN{1'b0}}, r.b};
    if (r.op == OP_MUL) begin
      return sa * sb;
    end
    // truncating division keeps the dividend sign on the remainder
    if (r.op == OP_DIV) begin
      quo = sa / sb;
      rem = sa % sb;
    end else begin
      quo = ua / ub;
      rem = ua % ub;
    end
    return {rem[XLEN-1:0], quo[XLEN-1:0]};
  endfunction

  // ------------------------------
  // monitor and checks
  // ------------------------------

  always @(posedge clk) begin
    if (reset) begin
      acc_last  <= 1'b0;
      resp_last <= 1'b0;
      n_req     <= 0;
      n_resp    <= 0;
      exp_count <= 0;
    end else begin
      if (resp_valid && resp_ready && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (req_valid && req_ready) begin
        exp_q.push_back(expected_result(req));
      end
      acc_last  <= req_valid && req_ready;
      resp_last <= resp_valid && resp_ready;
      n_req     <= n_req + ((req_valid && req_ready) ? 1 : 0);
      n_resp    <= n_resp + ((resp_valid && resp_ready) ? 1 : 0);
      exp_count <= exp_q.size();
      exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end
  end

  // every taken response matches the oldest outstanding request
  resp_order_check: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && resp_ready) |-> (exp_count != 0 && resp.result == exp_head))
    else stop_with_failure($sformatf("ERR @%0t: response expected %h got %h",
                                     $time, $sampled(exp_head),
                                     $sampled(resp.result)));

  // a valid response needs an unanswered request behind it
  resp_count_check: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> (n_resp < n_req))
    else stop_with_failure($sformatf("ERR @%0t: response without request, %0d req %0d resp",
                                     $time, $sampled(n_req), $sampled(n_resp)));

  // stalled response holds still
  resp_hold_check: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp.result)))
    else stop_with_failure($sformatf("ERR @%0t: held response changed or dropped", $time));

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      stop_with_failure("timeout, the run hung before all responses came back");
    end
  end

  // consumer is ready 70% of the time in the random phase
  always @(posedge clk) begin
    #1;
    resp_ready = random_ready ? ($urandom_range(99) < 70) : !reset;
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  task automatic send_op(input muldiv_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
    req.op    = op;
    req.a     = a;
    req.b     = b;
    req_valid = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!acc_last);
    req_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (n_resp != n_req) begin
      @(posedge clk);
      #1;
    end
  endtask

  // taken on the 33rd edge after acceptance with resp_ready high
  task automatic check_latency();
    int start;
    wait_drained();
    send_op(OP_MUL, 32'd1234, 32'd5678);
    start = cycle;
    do begin
      @(posedge clk);
      #1;
    end while (!resp_last);
    assert (cycle - start == 33)
      else stop_with_failure($sformatf("ERR @%0t: latency expected 33 got %0d",
                                       $time, cycle - start));
  endtask

  initial begin
    muldiv_op_e      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    void'($urandom(32'h7216_1743));
    reset      = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (!resp_valid && req_ready)
      else stop_with_failure($sformatf("ERR @%0t: not idle after reset", $time));

    // MUL corners
    send_op(OP_MUL, 32'd0, 32'd5);
    send_op(OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
    send_op(OP_MUL, 32'h8000_0000, 32'h8000_0000);
    send_op(OP_MUL, 32'h8000_0000, 32'hffff_ffff);
    send_op(OP_MUL, 32'd7, -32'd3);
    send_op(OP_MUL, -32'd12345, 32'd6789);
    send_op(OP_MUL, 32'h7fff_ffff, 32'h7fff_ffff);
    // DIVU with a small dividend and a unit divisor
    send_op(OP_DIVU, 32'd5, 32'd7);
    send_op(OP_DIVU, 32'hffff_ffff, 32'd1);
    send_op(OP_DIVU, 32'd100, 32'd7);
    send_op(OP_DIVU, 32'h8000_0000, 32'd3);
    // DIV over all sign pairs
    send_op(OP_DIV, 32'd7, 32'd2);
    send_op(OP_DIV, -32'd7, 32'd2);
    send_op(OP_DIV, 32'd7, -32'd2);
    send_op(OP_DIV, -32'd7, -32'd2);
    send_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    send_op(OP_DIV, 32'd5, -32'd7);

    // divide then multiply with both units in flight
    wait_drained();
    send_op(OP_DIV, -32'd1000, 32'd33);
    send_op(OP_MUL, -32'd44, 32'd55);
    assert (n_req - n_resp == 2)
      else stop_with_failure($sformatf("ERR @%0t: units not busy together", $time));
    check_latency();

    random_ready = 1'b1;
    repeat (NUM_RANDOM) begin
      op = muldiv_op_e'($urandom_range(2));
      a  = $urandom();
      b  = ($urandom_range(3) == 0) ? XLEN'($urandom_range(15) + 1) : $urandom();
      if (b == '0) begin
        b = 32'd1;
      end
      send_op(op, a, b);
    end

    random_ready = 1'b0;
    wait_drained();
    if (exp_q.size() == 0 && n_resp == n_req) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_with_failure("reference queue not empty at the end of the run");
    end
  end

endmodule
